// ==== Bender.yml ====
package:
  name: wb_data_cache

sources:
  - files:
      - source/cache_pkg.sv
      - source/line_access_if.sv
      - source/column_ram.sv
      - source/cache_line_store.sv
      - source/cache_tag_store.sv
      - source/burst_ctrl.sv
      - source/cache_top.sv
  - target: test
    files:
      - dv/burst_ram_model.sv
      - dv/cache_tb.sv

// ==== dv/burst_ram_model.sv ====
// ##########################################################################
// burst RAM model
// answers read commands with four 64-bit beats after a fixed latency and
// stores write beats as they arrive
// ##########################################################################
`timescale 1ns/1ps

module burst_ram_model
  import cache_pkg::*;
#(
  parameter int BR_ADDR_BITWIDTH = 21,
  parameter int BEAT_ADDR_BITWIDTH = 9,
  parameter int READ_LATENCY = 3,
  parameter word_t FILL_PATTERN = 32'h5a3c_96e1
) (
  input  logic                        clk,
  input  logic                        rst,
  input  br_cmd_e                     br_cmd,
  input  logic                        br_cmd_en,
  input  logic [BR_ADDR_BITWIDTH-1:0] br_addr,
  input  beat_t                       br_wr_data,
  output beat_t                       br_rd_data,
  output logic                        br_rd_data_valid
);

  localparam int BEAT_COUNT = 2 ** BEAT_ADDR_BITWIDTH;

  beat_t mem [BEAT_COUNT];
  logic [BEAT_ADDR_BITWIDTH-1:0] wr_ptr;
  int wr_left;
  logic [BEAT_ADDR_BITWIDTH-1:0] rd_base;
  int rd_step;

  // every word starts as its word address xor the pattern
  initial begin
    for (int i = 0; i < BEAT_COUNT; i++) begin
      mem[i] = {word_t'(2 * i + 1) ^ FILL_PATTERN, word_t'(2 * i) ^ FILL_PATTERN};
    end
    br_rd_data = '0;
    br_rd_data_valid = 1'b0;
  end

  always @(posedge clk) begin : ram_step
    int beat;
    beat_t rd_next;
    logic valid_next;
    rd_next = '0;
    valid_next = 1'b0;
    if (rst) begin
      wr_left = 0;
      rd_step = 0;
    end else begin
      // beats 1 to 3 follow the write command on consecutive cycles
      if (wr_left > 0) begin
        mem[wr_ptr] = br_wr_data;
        wr_ptr = wr_ptr + 1'b1;
        wr_left = wr_left - 1;
      end
      if (br_cmd_en && br_cmd == BR_WRITE) begin
        wr_ptr = br_addr[BEAT_ADDR_BITWIDTH-1:0];
        mem[wr_ptr] = br_wr_data;
        wr_ptr = wr_ptr + 1'b1;
        wr_left = BEATS_PER_LINE - 1;
      end

      if (rd_step > 0) begin
        if (rd_step >= READ_LATENCY) begin
          beat = rd_step - READ_LATENCY;
          rd_next = mem[rd_base + beat];
          // valid marks the first beat only
          valid_next = (beat == 0);
        end
        if (rd_step == READ_LATENCY + BEATS_PER_LINE - 1) begin
          rd_step = 0;
        end else begin
          rd_step = rd_step + 1;
        end
      end
      if (br_cmd_en && br_cmd == BR_READ) begin
        rd_base = br_addr[BEAT_ADDR_BITWIDTH-1:0];
        rd_step = 1;
      end
    end
    br_rd_data <= #2 rd_next;
    br_rd_data_valid <= #2 valid_next;
  end

endmodule

// ==== dv/cache_tb.sv ====
// ##########################################################################
// cache testbench
// random host traffic checked against a reference memory, with a burst
// RAM model behind the cache
// ##########################################################################
`timescale 1ns/1ps

module cache_tb
  import cache_pkg::*;
();

  localparam int LINE_IX_BITWIDTH = 4;
  localparam int BURST_RAM_DEPTH_BITWIDTH = 21;
  localparam int COMMAND_DELAY_INTERVAL = 13;
  // host traffic stays inside a 4 KB window
  localparam int ADDR_WORD_BITWIDTH = 10;
  localparam int WORD_COUNT = 2 ** ADDR_WORD_BITWIDTH;
  localparam int TAG_LSB = LINE_IX_LSB + LINE_IX_BITWIDTH;
  localparam int TAG_VALUES = 2 ** (ADDR_WORD_BITWIDTH + ZEROS_BITWIDTH - TAG_LSB);
  localparam word_t FILL_PATTERN = 32'h5a3c_96e1;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int RANDOM_OPS = 300;
  localparam int SEED = 41623;

  logic clk;
  logic rst;
  word_t address;
  word_t data_in;
  byte_en_t write_enable;
  word_t data_out;
  logic data_out_ready;
  logic busy;
  br_cmd_e br_cmd;
  logic br_cmd_en;
  logic [BURST_RAM_DEPTH_BITWIDTH-1:0] br_addr;
  beat_t br_wr_data;
  beat_t br_rd_data;
  logic br_rd_data_valid;

  word_t ref_mem [WORD_COUNT];
  int checks = 0;
  int errors = 0;
  int spacing_errors = 0;
  int cmd_count = 0;
  int cycle_count = 0;
  int last_cmd_cycle = 0;

  cache_top #(
    .LINE_IX_BITWIDTH        (LINE_IX_BITWIDTH),
    .BURST_RAM_DEPTH_BITWIDTH(BURST_RAM_DEPTH_BITWIDTH),
    .COMMAND_DELAY_INTERVAL  (COMMAND_DELAY_INTERVAL)
  ) DUT (
    .clk             (clk),
    .rst             (rst),
    .address         (address),
    .data_in         (data_in),
    .write_enable    (write_enable),
    .data_out        (data_out),
    .data_out_ready  (data_out_ready),
    .busy            (busy),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  burst_ram_model #(
    .BR_ADDR_BITWIDTH  (BURST_RAM_DEPTH_BITWIDTH),
    .BEAT_ADDR_BITWIDTH(ADDR_WORD_BITWIDTH - 1),
    .READ_LATENCY      (3),
    .FILL_PATTERN      (FILL_PATTERN)
  ) ram (
    .clk             (clk),
    .rst             (rst),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // burst commands must be spaced by at least the interval plus one
  always @(negedge clk) begin
    if (!rst && br_cmd_en) begin
      if (cmd_count > 0 && cycle_count - last_cmd_cycle < COMMAND_DELAY_INTERVAL + 1) begin
        $display("ERROR: burst commands only %0d cycles apart",
                 cycle_count - last_cmd_cycle);
        spacing_errors++;
      end
      cmd_count++;
      last_cmd_cycle = cycle_count;
    end
    cycle_count++;
  end

  function automatic int word_index(word_t addr);
    return int'(addr[ADDR_WORD_BITWIDTH+1:2]);
  endfunction

  function automatic word_t merge_bytes(word_t old, byte_en_t be, word_t data);
    word_t result;
    result = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = data[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic wait_not_busy(input string name, output bit ok);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (busy && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    ok = !busy;
    if (!ok) begin
      $display("ERROR: %s timed out, busy still high after %0d cycles", name, TIMEOUT_CYCLES);
      errors++;
    end
  endtask

  task automatic read_check(input word_t addr, input string name);
    bit ok;
    word_t expected;
    expected = ref_mem[word_index(addr)];
    address = addr;
    write_enable = '0;
    wait_not_busy(name, ok);
    if (ok) begin
      checks++;
      if (!data_out_ready) begin
        $display("ERROR: %s data_out_ready low with busy low at address %h", name, addr);
        errors++;
      end else if (data_out !== expected) begin
        $display("MISMATCH %s addr %h expected %h actual %h", name, addr, expected, data_out);
        errors++;
      end
    end
    @(posedge clk);
    #2;
  endtask

  task automatic write_word(input word_t addr, input byte_en_t be, input word_t data,
                            input string name);
    bit ok;
    address = addr;
    data_in = data;
    write_enable = be;
    wait_not_busy(name, ok);
    // the write lands on this edge
    @(posedge clk);
    if (ok) begin
      ref_mem[word_index(addr)] = merge_bytes(ref_mem[word_index(addr)], be, data);
    end
    #2;
    write_enable = '0;
  endtask

  // victim line in the burst RAM must match the reference after write-back
  task automatic check_writeback(input word_t victim_addr, input string name);
    int line_word;
    beat_t expected;
    line_word = (word_index(victim_addr) / COLUMN_COUNT) * COLUMN_COUNT;
    for (int k = 0; k < BEATS_PER_LINE; k++) begin
      expected = {ref_mem[line_word + 2 * k + 1], ref_mem[line_word + 2 * k]};
      checks++;
      if (ram.mem[line_word / 2 + k] !== expected) begin
        $display("MISMATCH %s beat %0d expected %h actual %h", name, line_word / 2 + k,
                 expected, ram.mem[line_word / 2 + k]);
        errors++;
      end
    end
  endtask

  initial begin : stimulus
    word_t addr_a;
    word_t addr_b;
    word_t wdata;
    byte_en_t be;
    void'($urandom(SEED));
    for (int w = 0; w < WORD_COUNT; w++) begin
      ref_mem[w] = word_t'(w) ^ FILL_PATTERN;
    end
    address = '0;
    data_in = '0;
    write_enable = '0;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    addr_a = word_t'($urandom_range(0, WORD_COUNT - 1)) << 2;
    read_check(addr_a, "cold_read");

    be = byte_en_t'($urandom_range(1, 15));
    wdata = $urandom;
    write_word(addr_a, be, wdata, "write_hit");
    read_check(addr_a, "write_hit");

    // same line index, different tag forces the dirty line out
    addr_a = word_t'($urandom_range(0, WORD_COUNT - 1)) << 2;
    addr_b = addr_a ^ (word_t'($urandom_range(1, TAG_VALUES - 1)) << TAG_LSB);
    write_word(addr_a, 4'hf, $urandom, "evict_write");
    read_check(addr_b, "evict_conflict");
    check_writeback(addr_a, "writeback");
    read_check(addr_a, "evict_refetch");

    for (int i = 0; i < RANDOM_OPS; i++) begin
      addr_a = word_t'($urandom_range(0, WORD_COUNT - 1)) << 2;
      if ($urandom_range(0, 1) == 1) begin
        write_word(addr_a, byte_en_t'($urandom_range(1, 15)), $urandom, "random_write");
      end else begin
        read_check(addr_a, "random_read");
      end
    end

    $display("checks %0d, errors %0d, spacing errors %0d, burst commands %0d",
             checks, errors, spacing_errors, cmd_count);
    if (errors == 0 && spacing_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== source/burst_ctrl.sv ====
// ##########################################################################
// burst controller
// miss FSM, burst read fill and dirty line write-back,
// with the spacing counter between burst commands
// ##########################################################################
`timescale 1ns/1ps

module burst_ctrl
  import cache_pkg::*;
#(
  parameter int LINE_IX_BITWIDTH = 8,
  parameter int BURST_RAM_DEPTH_BITWIDTH = 21,
  parameter int COMMAND_DELAY_INTERVAL = 13
) (
  input  logic                                clk,
  input  logic                                rst,
  input  word_t                               address,
  output logic                                busy,
  output br_cmd_e                             br_cmd,
  output logic                                br_cmd_en,
  output logic [BURST_RAM_DEPTH_BITWIDTH-1:0] br_addr,
  output beat_t                               br_wr_data,
  input  beat_t                               br_rd_data,
  input  logic                                br_rd_data_valid,
  line_access_if.ctrl acc
);

  localparam int CNT_BITWIDTH = $clog2(COMMAND_DELAY_INTERVAL + 2);
  localparam int BEAT_IX_BITWIDTH = $clog2(BEATS_PER_LINE);
  localparam int LINE_ADDR_BITWIDTH = 32 - LINE_IX_LSB;

  ctrl_state_e state;
  logic [BEAT_IX_BITWIDTH-1:0] beat_ix;
  logic [CNT_BITWIDTH-1:0] cmd_delay_cnt;
  logic [LINE_IX_BITWIDTH-1:0] line_ix;
  logic [LINE_ADDR_BITWIDTH-1:0] fetch_line;
  logic [LINE_ADDR_BITWIDTH-1:0] victim_line;
  logic last_beat;
  logic start_miss;
  logic issue_write;
  logic issue_read;
  logic beat_strobe;
  beat_t evict_data;

  assign line_ix = address[LINE_IX_LSB +: LINE_IX_BITWIDTH];
  assign fetch_line = address[31:LINE_IX_LSB];
  assign victim_line = {acc.victim_tag, line_ix};
  assign last_beat = beat_ix == BEAT_IX_BITWIDTH'(BEATS_PER_LINE - 1);

  assign start_miss = (state == IDLE) && !acc.hit && (cmd_delay_cnt == '0);
  assign issue_write = start_miss && acc.dirty;
  // a read either starts a clean miss or follows the write-back
  assign issue_read = (start_miss && !acc.dirty) ||
                      ((state == EVICT_WAIT) && (cmd_delay_cnt == '0));

  assign busy = !acc.hit || (cmd_delay_cnt != '0);

  // beat n of the victim holds columns 2n and 2n+1
  assign evict_data = {acc.line_words[{beat_ix, 1'b1}], acc.line_words[{beat_ix, 1'b0}]};

  // fill beats go straight into the line store as they arrive
  assign beat_strobe = (state == FILL_BEAT) || ((state == FILL_WAIT) && br_rd_data_valid);
  assign acc.fill_data = br_rd_data;
  assign acc.fill_beat_we = beat_strobe ? (BEATS_PER_LINE'(1) << beat_ix) : '0;
  assign acc.filling = state inside {FILL_WAIT, FILL_BEAT, FILL_TAG};
  assign acc.tag_write = state == FILL_TAG;
  assign acc.evicting = state inside {EVICT_BEAT, EVICT_WAIT};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      beat_ix <= '0;
      cmd_delay_cnt <= '0;
      br_cmd_en <= 1'b0;
    end else begin
      br_cmd_en <= issue_write || issue_read;
      if (issue_write || issue_read) begin
        cmd_delay_cnt <= CNT_BITWIDTH'(COMMAND_DELAY_INTERVAL);
      end else if (cmd_delay_cnt != '0) begin
        cmd_delay_cnt <= cmd_delay_cnt - 1'b1;
      end

      case (state)
        IDLE: begin
          if (issue_write) begin
            beat_ix <= beat_ix + 1'b1;
            state <= EVICT_BEAT;
          end else if (issue_read) begin
            state <= FILL_WAIT;
          end
        end
        EVICT_BEAT: begin
          beat_ix <= beat_ix + 1'b1;
          if (last_beat) begin
            state <= EVICT_WAIT;
          end
        end
        EVICT_WAIT: begin
          if (issue_read) begin
            state <= FILL_WAIT;
          end
        end
        FILL_WAIT: begin
          if (br_rd_data_valid) begin
            beat_ix <= beat_ix + 1'b1;
            state <= FILL_BEAT;
          end
        end
        FILL_BEAT: begin
          // beat index wraps back to zero after the last beat
          beat_ix <= beat_ix + 1'b1;
          if (last_beat) begin
            state <= FILL_TAG;
          end
        end
        FILL_TAG: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // command payload
  always_ff @(posedge clk) begin
    if (issue_write || state == EVICT_BEAT) begin
      br_wr_data <= evict_data;
    end
    if (issue_write) begin
      br_cmd <= BR_WRITE;
      br_addr <= BURST_RAM_DEPTH_BITWIDTH'(victim_line * BEATS_PER_LINE);
    end else if (issue_read) begin
      br_cmd <= BR_READ;
      br_addr <= BURST_RAM_DEPTH_BITWIDTH'(fetch_line * BEATS_PER_LINE);
    end
  end

  // RAM controller spacing between any two commands
  cmd_spacing: assert property (
    @(posedge clk) disable iff (rst) br_cmd_en |=> !br_cmd_en [*COMMAND_DELAY_INTERVAL]
  );

endmodule

// ==== source/cache_line_store.sv ====
// ##########################################################################
// cache line store
// eight column RAMs, steered by host write hits or by burst fill beats,
// with the column read multiplexer
// ##########################################################################
`timescale 1ns/1ps

module cache_line_store
  import cache_pkg::*;
#(
  parameter int LINE_IX_BITWIDTH = 8
) (
  input  logic     clk,
  input  word_t    address,
  input  byte_en_t write_enable,
  input  word_t    data_in,
  output word_t    data_out,
  line_access_if.lines acc
);

  logic [LINE_IX_BITWIDTH-1:0] line_ix;
  column_ix_t column_ix;
  logic host_write;
  word_t [COLUMN_COUNT-1:0] col_rdata;

  assign line_ix = address[LINE_IX_LSB +: LINE_IX_BITWIDTH];
  assign column_ix = column_ix_of(address);

  // writes stall while the victim line is being sent out
  assign host_write = (write_enable != '0) && acc.hit && !acc.evicting;

  for (genvar c = 0; c < COLUMN_COUNT; c++) begin : g_column
    byte_en_t we;
    word_t wdata;

    always_comb begin
      if (acc.filling) begin
        // beat n carries columns 2n (low half) and 2n+1 (high half)
        we = acc.fill_beat_we[c / 2] ? 4'hf : 4'h0;
        wdata = (c % 2 == 1) ? acc.fill_data[63:32] : acc.fill_data[31:0];
      end else begin
        we = (host_write && column_ix == c) ? write_enable : 4'h0;
        wdata = data_in;
      end
    end

    column_ram #(
      .LINE_IX_BITWIDTH(LINE_IX_BITWIDTH)
    ) u_column (
      .clk    (clk),
      .line_ix(line_ix),
      .we     (we),
      .wdata  (wdata),
      .rdata  (col_rdata[c])
    );
  end

  assign data_out = col_rdata[column_ix];
  // whole line goes to the controller for write-back
  assign acc.line_words = col_rdata;

  // the controller must present one beat per cycle during a fill
  fill_one_pair: assert property (
    @(posedge clk) acc.filling |-> $onehot0(acc.fill_beat_we)
  );

endmodule

// ==== source/cache_pkg.sv ====
// ##########################################################################
// cache package
// address split, bus widths, burst beat types and the enums shared by the
// cache blocks
// ##########################################################################

package cache_pkg;

  // host address layout  |tag|line|col|00|
  localparam int ZEROS_BITWIDTH = 2;
  localparam int COLUMN_IX_BITWIDTH = 3;
  localparam int COLUMN_COUNT = 2 ** COLUMN_IX_BITWIDTH;
  // one line is one burst of 64-bit beats
  localparam int BEATS_PER_LINE = 4;
  // lowest address bit of the line index
  localparam int LINE_IX_LSB = COLUMN_IX_BITWIDTH + ZEROS_BITWIDTH;

  typedef logic [31:0] word_t;
  typedef logic [3:0] byte_en_t;
  typedef logic [63:0] beat_t;
  typedef logic [COLUMN_IX_BITWIDTH-1:0] column_ix_t;

  typedef enum logic {
    BR_READ  = 1'b0,
    BR_WRITE = 1'b1
  } br_cmd_e;

  typedef enum logic [2:0] {
    IDLE,
    FILL_WAIT,
    FILL_BEAT,
    FILL_TAG,
    EVICT_BEAT,
    EVICT_WAIT
  } ctrl_state_e;

  function automatic column_ix_t column_ix_of(word_t address);
    return address[ZEROS_BITWIDTH +: COLUMN_IX_BITWIDTH];
  endfunction

endpackage

// ==== source/cache_tag_store.sv ====
// ##########################################################################
// cache tag store
// tag, valid and dirty flags per line with hit detection
// ##########################################################################
`timescale 1ns/1ps

module cache_tag_store
  import cache_pkg::*;
#(
  parameter int LINE_IX_BITWIDTH = 8
) (
  input  logic     clk,
  input  logic     rst,
  input  word_t    address,
  input  byte_en_t write_enable,
  line_access_if.tags acc
);

  localparam int LINE_COUNT = 2 ** LINE_IX_BITWIDTH;
  localparam int TAG_BITWIDTH = 32 - LINE_IX_BITWIDTH - LINE_IX_LSB;

  logic [TAG_BITWIDTH-1:0] tag_mem [LINE_COUNT];
  logic [LINE_COUNT-1:0] valid;
  logic [LINE_COUNT-1:0] dirty;
  logic [LINE_IX_BITWIDTH-1:0] line_ix;
  logic [TAG_BITWIDTH-1:0] addr_tag;
  logic host_write_hit;

  assign line_ix = address[LINE_IX_LSB +: LINE_IX_BITWIDTH];
  assign addr_tag = address[31 -: TAG_BITWIDTH];

  assign acc.hit = valid[line_ix] && (tag_mem[line_ix] == addr_tag);
  assign acc.dirty = dirty[line_ix];
  assign acc.victim_tag = tag_mem[line_ix];

  assign host_write_hit = (write_enable != '0) && acc.hit && !acc.filling && !acc.evicting;

  always_ff @(posedge clk) begin
    if (acc.tag_write) begin
      tag_mem[line_ix] <= addr_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      dirty <= '0;
    end else if (acc.tag_write) begin
      // freshly fetched line is clean
      valid[line_ix] <= 1'b1;
      dirty[line_ix] <= 1'b0;
    end else if (host_write_hit) begin
      dirty[line_ix] <= 1'b1;
    end
  end

endmodule

// ==== source/cache_top.sv ====
// ##########################################################################
// write-back data cache
// direct-mapped cache in front of a burst RAM controller
// ##########################################################################
`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
#(
  parameter int LINE_IX_BITWIDTH = 8,
  parameter int BURST_RAM_DEPTH_BITWIDTH = 21,
  parameter int COMMAND_DELAY_INTERVAL = 13
) (
  input  logic                                clk,
  input  logic                                rst,
  input  word_t                               address,
  input  word_t                               data_in,
  input  byte_en_t                            write_enable,
  output word_t                               data_out,
  output logic                                data_out_ready,
  output logic                                busy,
  output br_cmd_e                             br_cmd,
  output logic                                br_cmd_en,
  output logic [BURST_RAM_DEPTH_BITWIDTH-1:0] br_addr,
  output beat_t                               br_wr_data,
  input  beat_t                               br_rd_data,
  input  logic                                br_rd_data_valid
);

  line_access_if #(
    .LINE_IX_BITWIDTH(LINE_IX_BITWIDTH)
  ) acc ();

  cache_tag_store #(
    .LINE_IX_BITWIDTH(LINE_IX_BITWIDTH)
  ) u_tags (
    .clk         (clk),
    .rst         (rst),
    .address     (address),
    .write_enable(write_enable),
    .acc         (acc.tags)
  );

  cache_line_store #(
    .LINE_IX_BITWIDTH(LINE_IX_BITWIDTH)
  ) u_lines (
    .clk         (clk),
    .address     (address),
    .write_enable(write_enable),
    .data_in     (data_in),
    .data_out    (data_out),
    .acc         (acc.lines)
  );

  burst_ctrl #(
    .LINE_IX_BITWIDTH        (LINE_IX_BITWIDTH),
    .BURST_RAM_DEPTH_BITWIDTH(BURST_RAM_DEPTH_BITWIDTH),
    .COMMAND_DELAY_INTERVAL  (COMMAND_DELAY_INTERVAL)
  ) u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .address         (address),
    .busy            (busy),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid),
    .acc             (acc.ctrl)
  );

  // read data is good on a hit once the spacing counter has run out
  assign data_out_ready = acc.hit && !busy && (write_enable == '0);

endmodule

// ==== source/column_ram.sv ====
// ##########################################################################
// column RAM
// one 32-bit column of every cache line, byte-enabled write
// ##########################################################################
`timescale 1ns/1ps

module column_ram
  import cache_pkg::*;
#(
  parameter int LINE_IX_BITWIDTH = 8
) (
  input  logic                        clk,
  input  logic [LINE_IX_BITWIDTH-1:0] line_ix,
  input  byte_en_t                    we,
  input  word_t                       wdata,
  output word_t                       rdata
);

  word_t mem [2 ** LINE_IX_BITWIDTH];

  // read is asynchronous so a hit returns data in the same cycle
  assign rdata = mem[line_ix];

  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (we[b]) begin
        mem[line_ix][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

endmodule

// ==== source/line_access_if.sv ====
// ##########################################################################
// line access interface
// joins the burst controller with the tag store and the line store
// ##########################################################################
`timescale 1ns/1ps

interface line_access_if
  import cache_pkg::*;
#(
  parameter int LINE_IX_BITWIDTH = 8
);

  localparam int TAG_BITWIDTH = 32 - LINE_IX_BITWIDTH - LINE_IX_LSB;

  // tag store results for the host address
  logic hit;
  logic dirty;
  logic [TAG_BITWIDTH-1:0] victim_tag;

  // fill path from the controller
  logic filling;
  beat_t fill_data;
  logic [BEATS_PER_LINE-1:0] fill_beat_we;
  logic tag_write;

  // write-back path
  word_t [COLUMN_COUNT-1:0] line_words;
  logic evicting;

  modport ctrl (
    input  hit, dirty, victim_tag, line_words,
    output filling, fill_data, fill_beat_we, tag_write, evicting
  );

  modport tags (
    output hit, dirty, victim_tag,
    input  filling, tag_write, evicting
  );

  modport lines (
    output line_words,
    input  hit, filling, fill_data, fill_beat_we, evicting
  );

endinterface

// ==== vlog.f ====
source/cache_pkg.sv
source/line_access_if.sv
source/column_ram.sv
source/cache_line_store.sv
source/cache_tag_store.sv
source/burst_ctrl.sv
source/cache_top.sv
dv/burst_ram_model.sv
dv/cache_tb.sv
